// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f sim.f --top-module audio_conv_tb -o sim_bin
	./obj_dir/sim_bin > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== audio_conv_assert.sv ====
module audio_conv_assert import audio_pkg::*; #(
  parameter int KIND = 0  // 0 recorder, 1 convolver, 2 i2s receiver
) (
  input logic       audio_clk,
  input logic       rst_in,
  input logic       sig_a,
  input logic       sig_b,
  input rec_state_t state
);

  timeunit 1ns;
  timeprecision 100ps;

  generate
    if (KIND == 0) begin : g_rec
      // sig_a is wr_en, sig_b is ir_recorded
      a_wr_in_capture: assert property (@(posedge audio_clk) disable iff (rst_in)
        sig_a |-> (state == REC_CAPTURE))
        else $error("impulse write outside the capture state");
      a_wr_not_recorded: assert property (@(posedge audio_clk) disable iff (rst_in)
        sig_a |-> !sig_b)
        else $error("ir_recorded high during an impulse write");
    end else if (KIND == 1) begin : g_conv
      a_single_strobe: assert property (@(posedge audio_clk) disable iff (rst_in)
        sig_a |=> !sig_a)
        else $error("conv_valid held for two cycles");
    end else begin : g_i2s
      // word clock moves with the bit clock falling edge
      a_lrcl_on_fall: assert property (@(posedge audio_clk) disable iff (rst_in)
        $changed(sig_a) |-> $fell(sig_b))
        else $error("lrcl_clk changed away from an i2s_clk fall");
    end
  endgenerate

endmodule

bind impulse_recorder audio_conv_assert #(.KIND(0)) i_rec_chk (
  .audio_clk(audio_clk), .rst_in(rst_in),
  .sig_a(ir_wr.wr_en), .sig_b(ir_recorded), .state(state)
);

bind ir_convolver audio_conv_assert #(.KIND(1)) i_conv_chk (
  .audio_clk(audio_clk), .rst_in(rst_in),
  .sig_a(conv_valid), .sig_b(1'b0), .state(REC_IDLE)
);

bind i2s_receiver audio_conv_assert #(.KIND(2)) i_i2s_chk (
  .audio_clk(audio_clk), .rst_in(rst_in),
  .sig_a(lrcl_clk), .sig_b(i2s_clk), .state(REC_IDLE)
);

// ==== audio_conv_tb.sv ====
module audio_conv_tb import audio_pkg::*; ;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BCLK_DIV  = 4;
  localparam int IR_LEN    = 16;
  localparam int DC_SHIFT  = 8;
  localparam int OUT_SHIFT = 15;
  localparam int N_FRAMES  = 140;
  localparam longint WD_NS = longint'(N_FRAMES + 20) * 256 * BCLK_DIV / 4 * 10;

  logic       audio_clk;
  logic       rst_in;
  logic       mic_data;
  logic       record_trigger;
  logic [7:0] delay_length;
  logic       i2s_clk;
  logic       lrcl_clk;
  sample_t    audio_out;
  logic       audio_valid;
  logic       ir_recorded;
  acc_t       conv_out;
  logic       conv_valid;
  logic       pdm_out;

  logic [MIC_W-1:0] word_q[$];  // words still to send
  sample_t          raw_q[$];   // top bits as sent
  acc_t             conv_q[$];
  longint           due_q[$];   // cycle when conv_valid is due

  // reference state
  sample_t ref_x;
  sample_t ref_y;
  sample_t ref_hist[IR_LEN];
  sample_t ref_ir[IR_LEN];
  int      rec_skip;
  int      rec_idx;
  bit      rec_busy;
  bit      ref_ir_ok;

  int     n_samples;
  longint cycle;
  int     err_audio;
  int     err_conv;
  int     err_rec;
  int     err_pdm;
  int     err_other;

  audio_conv_top #(
    .BCLK_DIV(BCLK_DIV), .IR_LEN(IR_LEN), .DC_SHIFT(DC_SHIFT), .OUT_SHIFT(OUT_SHIFT)
  ) i_dut (
    .audio_clk(audio_clk), .rst_in(rst_in), .mic_data(mic_data),
    .record_trigger(record_trigger), .delay_length(delay_length),
    .i2s_clk(i2s_clk), .lrcl_clk(lrcl_clk), .audio_out(audio_out),
    .audio_valid(audio_valid), .ir_recorded(ir_recorded), .conv_out(conv_out),
    .conv_valid(conv_valid), .pdm_out(pdm_out)
  );

  initial begin
    audio_clk = 1'b0;
    forever #5 audio_clk = ~audio_clk;
  end

  // one sample through dc blocker, history, convolution and recorder
  function automatic void ref_model(input sample_t x, output sample_t y_exp,
                                    output bit conv_exp, output acc_t conv_val);
    longint sum;
    y_exp = x - ref_x + ref_y - (ref_y >>> DC_SHIFT);
    ref_x = x;
    ref_y = y_exp;
    for (int k = IR_LEN - 1; k > 0; k--) ref_hist[k] = ref_hist[k-1];
    ref_hist[0] = y_exp;
    conv_exp = ref_ir_ok;
    sum = 0;
    for (int k = 0; k < IR_LEN; k++) sum += longint'(ref_ir[k]) * longint'(ref_hist[k]);
    conv_val = acc_t'(sum);
    if (rec_busy) begin
      if (rec_skip > 0) begin
        rec_skip--;
      end else begin
        ref_ir[rec_idx] = y_exp;
        rec_idx++;
        if (rec_idx == IR_LEN) begin
          rec_busy  = 1'b0;
          ref_ir_ok = 1'b1;
        end
      end
    end
  endfunction

  function automatic void ref_trigger(input int d);
    rec_busy  = 1'b1;
    rec_skip  = d;
    rec_idx   = 0;
    ref_ir_ok = 1'b0;
  endfunction

  function automatic longint scale_level(input acc_t v);
    longint s;
    s = longint'(v) >>> OUT_SHIFT;
    if (s > 32767) s = 32767;
    else if (s < -32768) s = -32768;
    return s;
  endfunction

  task automatic wait_samples(input int n);
    int target;
    target = n_samples + n;
    while (n_samples < target) @(posedge audio_clk);
  endtask

  // trigger well clear of any running convolution
  task automatic pulse_trigger();
    int d;
    wait_samples(1);
    repeat (30) @(posedge audio_clk);
    #1;
    d = $urandom % 8;
    delay_length   = 8'(d);
    record_trigger = 1'b1;
    ref_trigger(d);
    @(posedge audio_clk);
    #1 record_trigger = 1'b0;
  endtask

  // microphone, left word msb first from bit clock 1
  initial begin
    logic [MIC_W-1:0] word;
    int pos;
    realtime t_fall;  // previous bit clock fall
    mic_data = 1'b0;
    pos = 0;
    word = '0;
    t_fall = 0.0;
    forever begin
      @(negedge i2s_clk);
      #1;
      if (rst_in) begin
        pos = 0;
        t_fall = 0.0;
        mic_data = 1'b0;
      end else begin
        if (t_fall > 0.0) begin
          assert ($realtime - t_fall == BCLK_DIV * 10.0) else begin
            err_other++;
            $display("i2s_clk period was %0.1f ns instead of %0d ns",
                     $realtime - t_fall, BCLK_DIV * 10);
          end
        end
        t_fall = $realtime;
        pos = (pos + 1) % FRAME_BITS;
        // word clock high for the right half of the frame
        assert (lrcl_clk == (pos >= FRAME_BITS / 2)) else begin
          err_other++;
          $display("FAILED lrcl_clk expected %h actual %h", pos >= FRAME_BITS / 2, lrcl_clk);
        end
        if (pos == 1) begin
          word = (word_q.size() > 0) ? word_q.pop_front() : '0;
          raw_q.push_back(sample_t'(word[MIC_W-1 -: SAMPLE_W]));
        end
        mic_data = (pos >= 1 && pos <= MIC_W) ? word[MIC_W-pos] : 1'b0;
      end
    end
  end

  // checker, samples at the falling edge
  initial begin
    sample_t x;
    sample_t y_e;
    bit      c_e;
    acc_t    c_v;
    acc_t    c_exp;
    longint  due;
    longint  lvl_d1;
    longint  lvl_d2;
    longint  win_level;
    longint  diff;
    bit      lvl_d1_ok;
    bit      lvl_d2_ok;
    bit      win_open;
    int      ones;
    int      len;
    bit      new_lvl;
    longint  new_val;
    cycle = 0;
    lvl_d1_ok = 0;
    lvl_d2_ok = 0;
    lvl_d1 = 0;
    lvl_d2 = 0;
    win_open = 0;
    win_level = 0;
    ones = 0;
    len = 0;
    forever begin
      @(negedge audio_clk);
      cycle++;
      new_lvl = 0;
      new_val = 0;
      if (!rst_in && audio_valid) begin
        if (raw_q.size() == 0) begin
          err_other++;
          $display("audio_valid arrived with no microphone word sent");
        end else begin
          x = raw_q.pop_front();
          assert (ir_recorded == ref_ir_ok) else begin
            err_rec++;
            $display("FAILED ir_recorded expected %h actual %h", ref_ir_ok, ir_recorded);
          end
          ref_model(x, y_e, c_e, c_v);
          assert (audio_out == y_e) else begin
            err_audio++;
            $display("FAILED audio_out expected %h actual %h", y_e, audio_out);
          end
          if (c_e) begin
            conv_q.push_back(c_v);
            due_q.push_back(cycle + IR_LEN + 2);
          end
          n_samples++;
        end
      end
      if (!rst_in && conv_valid) begin
        if (conv_q.size() == 0) begin
          err_conv++;
          $display("conv_valid pulsed when no convolution was expected");
        end else begin
          c_exp = conv_q.pop_front();
          due = due_q.pop_front();
          assert (conv_out == c_exp) else begin
            err_conv++;
            $display("FAILED conv_out expected %h actual %h", c_exp, conv_out);
          end
          assert (cycle == due) else begin
            err_conv++;
            $display("conv_valid came %0d cycles off its due time", cycle - due);
          end
          new_lvl = 1;
          new_val = scale_level(c_exp);
        end
      end
      // new level shows on pdm_out two cycles after conv_valid
      if (lvl_d2_ok) begin
        if (win_open) begin
          diff = longint'(ones) * 65536 - longint'(len) * (win_level + 32768);
          assert (diff <= 65536 && diff >= -65536) else begin
            err_pdm++;
            $display("FAILED pdm_out expected %h actual %h",
                     longint'(len) * (win_level + 32768) / 65536, ones);
          end
        end
        win_open = 1;
        win_level = lvl_d2;
        ones = 0;
        len = 0;
      end
      if (win_open) begin
        len++;
        ones += int'(pdm_out);
      end
      lvl_d2_ok = lvl_d1_ok;
      lvl_d2 = lvl_d1;
      lvl_d1_ok = new_lvl;
      lvl_d1 = new_val;
    end
  end

  initial begin
    #(WD_NS);
    $display("watchdog expired before the test sequence finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(20));
    rst_in = 1'b1;
    record_trigger = 1'b0;
    delay_length = 8'd0;
    n_samples = 0;
    err_audio = 0;
    err_conv = 0;
    err_rec = 0;
    err_pdm = 0;
    err_other = 0;
    ref_x = '0;
    ref_y = '0;
    rec_busy = 0;
    rec_skip = 0;
    rec_idx = 0;
    ref_ir_ok = 0;
    for (int k = 0; k < IR_LEN; k++) begin
      ref_hist[k] = '0;
      ref_ir[k] = '0;
    end
    for (int f = 0; f < N_FRAMES; f++) begin
      if (f >= 12 && f < 24) word_q.push_back(24'h3a1200);  // constant step
      else word_q.push_back(MIC_W'($urandom));
    end
    repeat (2) @(posedge audio_clk);
    #1 rst_in = 1'b0;
    wait_samples(24);
    pulse_trigger();
    wait_samples(55);
    pulse_trigger();   // re-record with new taps
    while (n_samples < N_FRAMES) @(posedge audio_clk);
    repeat (40) @(posedge audio_clk);
    if (conv_q.size() != 0) begin
      err_other++;
      $display("%0d expected convolution results never arrived", conv_q.size());
    end
    total = err_audio + err_conv + err_rec + err_pdm + err_other;
    $display("errors: audio %0d conv %0d record %0d pdm %0d other %0d, samples %0d",
             err_audio, err_conv, err_rec, err_pdm, err_other, n_samples);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== audio_conv_top.sv ====
module audio_conv_top import audio_pkg::*; #(
  parameter int BCLK_DIV  = 4,
  parameter int IR_LEN    = 16,
  parameter int DC_SHIFT  = 8,
  parameter int OUT_SHIFT = 15
) (
  input  logic       audio_clk,
  input  logic       rst_in,
  input  logic       mic_data,
  input  logic       record_trigger,
  input  logic [7:0] delay_length,
  output logic       i2s_clk,
  output logic       lrcl_clk,
  output sample_t    audio_out,
  output logic       audio_valid,
  output logic       ir_recorded,
  output acc_t       conv_out,
  output logic       conv_valid,
  output logic       pdm_out
);

  sample_t mic_sample;  // raw top bits of the left word
  logic    mic_valid;

  ir_bus_if #(.IR_LEN(IR_LEN)) ir_bus ();

  i2s_receiver #(.BCLK_DIV(BCLK_DIV)) i_rx (
    .audio_clk(audio_clk), .rst_in(rst_in), .mic_data(mic_data),
    .i2s_clk(i2s_clk), .lrcl_clk(lrcl_clk),
    .sample(mic_sample), .sample_valid(mic_valid)
  );

  dc_blocker #(.DC_SHIFT(DC_SHIFT)) i_dc (
    .audio_clk(audio_clk), .rst_in(rst_in),
    .in_sample(mic_sample), .in_valid(mic_valid),
    .out_sample(audio_out), .out_valid(audio_valid)
  );

  impulse_recorder #(.IR_LEN(IR_LEN)) i_rec (
    .audio_clk(audio_clk), .rst_in(rst_in),
    .record_trigger(record_trigger), .delay_length(delay_length),
    .in_sample(audio_out), .in_valid(audio_valid),
    .ir_recorded(ir_recorded), .ir_wr(ir_bus.writer)
  );

  impulse_memory #(.IR_LEN(IR_LEN)) i_mem (
    .audio_clk(audio_clk), .bus(ir_bus.store)
  );

  ir_convolver #(.IR_LEN(IR_LEN)) i_conv (
    .audio_clk(audio_clk), .rst_in(rst_in),
    .in_sample(audio_out), .in_valid(audio_valid),
    .ir_recorded(ir_recorded), .ir_rd(ir_bus.reader),
    .conv_out(conv_out), .conv_valid(conv_valid)
  );

  pdm_modulator #(.OUT_SHIFT(OUT_SHIFT)) i_pdm (
    .audio_clk(audio_clk), .rst_in(rst_in),
    .conv_out(conv_out), .conv_valid(conv_valid), .pdm_out(pdm_out)
  );

endmodule

// ==== audio_pkg.sv ====
package audio_pkg;

  // audio word widths
  localparam int SAMPLE_W   = 16;
  localparam int MIC_W      = 24;  // bits per mic word
  localparam int FRAME_BITS = 64;  // bit clocks per stereo frame
  localparam int ACC_W      = 40;  // room for IR_LEN products of two samples

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // impulse capture sequence
  typedef enum logic [1:0] {
    REC_IDLE,
    REC_WAIT,     // counting delay strobes
    REC_CAPTURE,
    REC_DONE      // impulse valid in memory
  } rec_state_t;

  // one multiply-accumulate run per sample
  typedef enum logic [1:0] {
    CONV_IDLE,
    CONV_MAC,
    CONV_DRAIN    // last tap still in the read pipeline
  } conv_state_t;

endpackage

// ==== dc_blocker.sv ====
module dc_blocker import audio_pkg::*; #(
  parameter int DC_SHIFT = 8
) (
  input  logic    audio_clk,
  input  logic    rst_in,
  input  sample_t in_sample,
  input  logic    in_valid,
  output sample_t out_sample,
  output logic    out_valid
);

  sample_t x_prev;
  sample_t y_prev;
  sample_t y_next;

  // high-pass recurrence, wraps at 16 bits
  assign y_next = in_sample - x_prev + y_prev - (y_prev >>> DC_SHIFT);

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      x_prev    <= '0;
      y_prev    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        x_prev <= in_sample;
        y_prev <= y_next;
      end
    end
  end

  assign out_sample = y_prev;  // held until the next strobe

endmodule

// ==== i2s_receiver.sv ====
module i2s_receiver import audio_pkg::*; #(
  parameter int BCLK_DIV = 4  // even
) (
  input  logic    audio_clk,
  input  logic    rst_in,
  input  logic    mic_data,
  output logic    i2s_clk,
  output logic    lrcl_clk,
  output sample_t sample,
  output logic    sample_valid
);

  localparam int HALF  = BCLK_DIV / 2;
  localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;
  localparam int CNT_W = $clog2(FRAME_BITS);

  logic [DIV_W-1:0] div_cnt;
  logic [CNT_W-1:0] bit_cnt;   // bit clock index within the frame
  logic [CNT_W-1:0] bit_next;
  logic [MIC_W-1:0] shift_reg;
  logic [MIC_W-1:0] word_next;
  logic             half_done;
  logic             bclk_rise;
  logic             bclk_fall;
  logic             left_bit;
  logic             last_bit;

  assign half_done = (div_cnt == DIV_W'(HALF - 1));
  assign bclk_rise = half_done && !i2s_clk;
  assign bclk_fall = half_done && i2s_clk;
  assign bit_next  = bit_cnt + 1'b1;
  assign word_next = {shift_reg[MIC_W-2:0], mic_data};

  // left word sits in bit clocks 1..MIC_W, msb first
  assign left_bit = (bit_cnt >= CNT_W'(1)) && (bit_cnt <= CNT_W'(MIC_W));
  assign last_bit = (bit_cnt == CNT_W'(MIC_W));

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      div_cnt      <= '0;
      bit_cnt      <= '0;
      i2s_clk      <= 1'b0;
      lrcl_clk     <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      div_cnt      <= half_done ? '0 : div_cnt + 1'b1;
      sample_valid <= bclk_rise && last_bit;
      if (half_done) i2s_clk <= !i2s_clk;
      if (bclk_fall) begin
        bit_cnt  <= bit_next;
        lrcl_clk <= bit_next[CNT_W-1];  // high for the right half
      end
    end
  end

  // data path, sampled on bit clock rising edges
  always_ff @(posedge audio_clk) begin
    if (bclk_rise && left_bit) shift_reg <= word_next;
    if (bclk_rise && last_bit) sample <= word_next[MIC_W-1 -: SAMPLE_W];  // keep top bits
  end

endmodule

// ==== impulse_memory.sv ====
module impulse_memory import audio_pkg::*; #(
  parameter int IR_LEN = 16
) (
  input logic     audio_clk,
  ir_bus_if.store bus
);

  sample_t mem [IR_LEN];

  always_ff @(posedge audio_clk) begin
    if (bus.wr_en) mem[bus.wr_addr] <= bus.wr_data;
    bus.rd_data <= mem[bus.rd_addr];  // registered read
  end

endmodule

// ==== impulse_recorder.sv ====
module impulse_recorder import audio_pkg::*; #(
  parameter int IR_LEN = 16
) (
  input  logic       audio_clk,
  input  logic       rst_in,
  input  logic       record_trigger,
  input  logic [7:0] delay_length,
  input  sample_t    in_sample,
  input  logic       in_valid,
  output logic       ir_recorded,
  ir_bus_if.writer   ir_wr
);

  localparam int ADDR_W = (IR_LEN > 1) ? $clog2(IR_LEN) : 1;
  localparam logic [ADDR_W-1:0] LAST = ADDR_W'(IR_LEN - 1);

  rec_state_t        state;
  logic [7:0]        wait_cnt;  // strobes still to skip
  logic [ADDR_W-1:0] addr;

  // write goes out in the strobe cycle itself
  assign ir_wr.wr_en   = (state == REC_CAPTURE) && in_valid;
  assign ir_wr.wr_addr = addr;
  assign ir_wr.wr_data = in_sample;
  assign ir_recorded   = (state == REC_DONE);

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      state    <= REC_IDLE;
      wait_cnt <= '0;
      addr     <= '0;
    end else begin
      case (state)
        REC_IDLE, REC_DONE: begin
          if (record_trigger) begin
            state    <= REC_WAIT;
            wait_cnt <= delay_length;
            addr     <= '0;
          end
        end
        REC_WAIT: begin
          if (wait_cnt == 8'd0) begin
            state <= REC_CAPTURE;  // zero delay
          end else if (in_valid) begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == 8'd1) state <= REC_CAPTURE;
          end
        end
        REC_CAPTURE: begin
          if (in_valid) begin
            addr <= addr + 1'b1;
            if (addr == LAST) state <= REC_DONE;
          end
        end
        default: state <= REC_IDLE;
      endcase
    end
  end

endmodule

// ==== ir_bus_if.sv ====
interface ir_bus_if import audio_pkg::*; #(
  parameter int IR_LEN = 16
) ();

  localparam int ADDR_W = (IR_LEN > 1) ? $clog2(IR_LEN) : 1;

  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  sample_t           wr_data;
  logic [ADDR_W-1:0] rd_addr;
  sample_t           rd_data;  // one cycle after rd_addr

  modport writer (output wr_en, output wr_addr, output wr_data);
  modport reader (output rd_addr, input rd_data);
  modport store (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

// ==== ir_convolver.sv ====
module ir_convolver import audio_pkg::*; #(
  parameter int IR_LEN = 16
) (
  input  logic     audio_clk,
  input  logic     rst_in,
  input  sample_t  in_sample,
  input  logic     in_valid,
  input  logic     ir_recorded,
  ir_bus_if.reader ir_rd,
  output acc_t     conv_out,
  output logic     conv_valid
);

  localparam int ADDR_W = (IR_LEN > 1) ? $clog2(IR_LEN) : 1;
  localparam logic [ADDR_W-1:0] LAST = ADDR_W'(IR_LEN - 1);

  conv_state_t                  state;
  sample_t                      hist [IR_LEN];  // sample history ring
  logic [ADDR_W-1:0]            head;           // next slot to write
  logic [ADDR_W-1:0]            hist_ptr;       // history entry paired with tap
  logic [ADDR_W-1:0]            tap;
  sample_t                      hist_q;         // aligned with rd_data
  logic                         mac_en;
  logic signed [2*SAMPLE_W-1:0] prod;
  acc_t                         acc;

  assign ir_rd.rd_addr = tap;
  assign prod          = ir_rd.rd_data * hist_q;
  assign conv_out      = acc;

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      state      <= CONV_IDLE;
      head       <= '0;
      hist_ptr   <= '0;
      tap        <= '0;
      mac_en     <= 1'b0;
      acc        <= '0;
      conv_valid <= 1'b0;
      for (int i = 0; i < IR_LEN; i++) begin
        hist[i] <= '0;
      end
    end else begin
      conv_valid <= 1'b0;
      mac_en     <= (state == CONV_MAC) && ir_recorded;  // read data lands next cycle
      if (mac_en) acc <= acc + prod;

      // every sample goes into history, impulse or not
      if (in_valid) begin
        hist[head] <= in_sample;
        head       <= (head == LAST) ? '0 : head + 1'b1;
      end

      case (state)
        CONV_IDLE: begin
          if (in_valid && ir_recorded) begin
            state    <= CONV_MAC;
            tap      <= '0;
            hist_ptr <= head;  // newest sample pairs with tap 0
            acc      <= '0;
          end
        end
        CONV_MAC: begin
          if (!ir_recorded) begin
            state <= CONV_IDLE;  // re-record started, drop the run
          end else begin
            tap      <= tap + 1'b1;
            hist_ptr <= (hist_ptr == '0) ? LAST : hist_ptr - 1'b1;
            if (tap == LAST) state <= CONV_DRAIN;
          end
        end
        CONV_DRAIN: begin
          state      <= CONV_IDLE;
          conv_valid <= ir_recorded;
        end
        default: state <= CONV_IDLE;
      endcase
    end
  end

  always_ff @(posedge audio_clk) begin
    if (state == CONV_MAC) hist_q <= hist[hist_ptr];
  end

endmodule

// ==== pdm_modulator.sv ====
module pdm_modulator import audio_pkg::*; #(
  parameter int OUT_SHIFT = 15
) (
  input  logic audio_clk,
  input  logic rst_in,
  input  acc_t conv_out,
  input  logic conv_valid,
  output logic pdm_out
);

  localparam acc_t SAT_MAX = acc_t'(2 ** (SAMPLE_W - 1) - 1);
  localparam acc_t SAT_MIN = -acc_t'(2 ** (SAMPLE_W - 1));

  acc_t                scaled;
  sample_t             sat_level;
  sample_t             level;
  logic [SAMPLE_W-1:0] level_u;  // offset binary
  logic [SAMPLE_W:0]   sd_acc;   // carry bit is the output

  assign scaled  = conv_out >>> OUT_SHIFT;
  assign level_u = {~level[SAMPLE_W-1], level[SAMPLE_W-2:0]};
  assign pdm_out = sd_acc[SAMPLE_W];

  always_comb begin
    if (scaled > SAT_MAX) sat_level = sample_t'(SAT_MAX);
    else if (scaled < SAT_MIN) sat_level = sample_t'(SAT_MIN);
    else sat_level = sample_t'(scaled);
  end

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      level  <= '0;
      sd_acc <= '0;
    end else begin
      if (conv_valid) level <= sat_level;
      sd_acc <= {1'b0, sd_acc[SAMPLE_W-1:0]} + {1'b0, level_u};  // first-order sigma-delta
    end
  end

endmodule

// ==== sim.f ====
audio_pkg.sv
ir_bus_if.sv
i2s_receiver.sv
dc_blocker.sv
impulse_recorder.sv
impulse_memory.sv
ir_convolver.sv
pdm_modulator.sv
audio_conv_top.sv
audio_conv_assert.sv
audio_conv_tb.sv
